// ==== Bender.yml ====
package:
  name: axi_protocol_monitor

sources:
  - files:
      - axi_fields_pkg.sv
      - monitor_pkg.sv
      - axi_event_if.sv
      - monitor_viol_if.sv
      - axi_monitor_ctrl.sv
      - axi_latency_watch.sv
      - axi_id_tracker.sv
      - axi_burst_checker.sv
      - axi_protocol_monitor.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_axi_monitor.sv

// ==== all.f ====
+incdir+.
axi_fields_pkg.sv
monitor_pkg.sv
axi_event_if.sv
monitor_viol_if.sv
axi_monitor_ctrl.sv
axi_latency_watch.sv
axi_id_tracker.sv
axi_burst_checker.sv
axi_protocol_monitor.sv
tb_axi_monitor.sv

// ==== axi_burst_checker.sv ====
// Write and read beat counting against burst lengths, plus interleave and length limit checks
`timescale 1ns/1ps

module axi_burst_checker import axi_fields_pkg::*, monitor_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_axi_reset_n,
	axi_event_if.dst    ev,
	monitor_viol_if.src viol
);

	// Write side, one burst at a time
	logic              wr_pend;
	axi_len_t          wr_len_q;
	logic [BEAT_W-1:0] wr_cnt;        // Beats taken so far
	axi_len_t          wr_cur_len;
	logic [BEAT_W-1:0] wr_beat, wr_exp;
	logic              w_done;

	// Read side
	axi_len_t          rd_len [NUM_IDS];  // Pending length per ID
	logic              rd_busy;
	axi_id_t           rd_cur_id;
	logic [BEAT_W-1:0] rd_cnt;
	logic [BEAT_W-1:0] rd_beat, rd_exp;

	////////////////////
	// Write beats
	////////////////////
	assign w_done     = ev.w_fire && ev.w_last;
	assign wr_cur_len = wr_pend ? wr_len_q : ev.aw_len;  // Same-cycle AW counts
	assign wr_beat    = wr_cnt + 1'b1;
	assign wr_exp     = BEAT_W'(wr_cur_len) + 1'b1;

	assign viol.w_no_addr   = ev.w_fire && !wr_pend && !ev.aw_fire;
	assign viol.burst_len_w = ev.w_fire && (wr_pend || ev.aw_fire)
		&& (ev.w_last ? (wr_beat != wr_exp) : (wr_beat >= wr_exp));

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			wr_pend <= 1'b0;
			wr_cnt  <= '0;
		end
		else
		begin
			if (ev.aw_fire && (!wr_pend || w_done) && !(w_done && !wr_pend))
			begin
				wr_pend  <= 1'b1;
				wr_len_q <= ev.aw_len;
			end
			else if (w_done)
				wr_pend <= 1'b0;

			if (ev.w_fire)
				wr_cnt <= ev.w_last ? '0 : wr_beat;
		end
	end

	////////////////////
	// Read beats
	////////////////////
	assign rd_beat = rd_cnt + 1'b1;
	assign rd_exp  = BEAT_W'(rd_len[ev.r_id]) + 1'b1;

	assign viol.r_interleave = ev.r_fire && rd_busy && (ev.r_id != rd_cur_id);
	// Counter belongs to another ID when interleaved
	assign viol.burst_len_r  = ev.r_fire && !viol.r_interleave
		&& (ev.r_last ? (rd_beat != rd_exp) : (rd_beat >= rd_exp));

	always_ff @(posedge i_clk)
	begin
		if (ev.ar_fire)
			rd_len[ev.ar_id] <= ev.ar_len;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			rd_busy <= 1'b0;
			rd_cnt  <= '0;
		end
		else if (ev.r_fire)
		begin
			rd_busy   <= !ev.r_last;
			rd_cur_id <= ev.r_id;
			rd_cnt    <= ev.r_last ? '0 : rd_beat;
		end
	end

	assign viol.len_limit = (ev.aw_fire && (ev.aw_len > LEN_W'(MAX_BURST)))
		|| (ev.ar_fire && (ev.ar_len > LEN_W'(MAX_BURST)));

endmodule

// ==== axi_event_if.sv ====
// Decoded handshake events, driven by the control block and read by each checker
`timescale 1ns/1ps

interface axi_event_if import axi_fields_pkg::*; ();

	// Fire strobes, valid and ready high together
	logic     aw_fire;
	logic     w_fire;
	logic     b_fire;
	logic     ar_fire;
	logic     r_fire;

	// Side fields qualified by the fires
	axi_id_t  aw_id;
	axi_len_t aw_len;
	logic     w_last;
	axi_id_t  b_id;
	axi_id_t  ar_id;
	axi_len_t ar_len;
	axi_id_t  r_id;
	logic     r_last;

	logic     aw_valid;  // Raw levels for the stall timers
	logic     w_valid;
	logic     ar_valid;

	modport src (output aw_fire, w_fire, b_fire, ar_fire, r_fire, aw_id, aw_len, w_last,
		b_id, ar_id, ar_len, r_id, r_last, aw_valid, w_valid, ar_valid);
	modport dst (input aw_fire, w_fire, b_fire, ar_fire, r_fire, aw_id, aw_len, w_last,
		b_id, ar_id, ar_len, r_id, r_last, aw_valid, w_valid, ar_valid);

endinterface

// ==== axi_fields_pkg.sv ====
// AXI field widths, types and response codes shared by every monitor block
package axi_fields_pkg;

	////////////////////
	// Field widths
	////////////////////
	localparam int ID_W    = 3;     // AXI ID width
	localparam int NUM_IDS = 8;     // One bitmap slot per ID
	localparam int LEN_W   = 8;     // AxLEN field
	localparam int BEAT_W  = 9;     // Beat count, holds len plus one
	localparam int RESP_W  = 2;     // xRESP field
	localparam int CNT_W   = 4;     // Outstanding burst count

	typedef logic [ID_W-1:0]  axi_id_t;
	typedef logic [LEN_W-1:0] axi_len_t;

	// Response codes, high bit set means an error
	typedef enum logic [RESP_W-1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_t;

endpackage

// ==== axi_id_tracker.sv ====
// Per-ID outstanding bitmaps and burst counters, flags ID reuse and orphan responses
`timescale 1ns/1ps

module axi_id_tracker import axi_fields_pkg::*;
(
	input  logic             i_clk,
	input  logic             i_axi_reset_n,
	axi_event_if.dst         ev,
	output logic [CNT_W-1:0] o_wr_outstanding,
	output logic [CNT_W-1:0] o_rd_outstanding,
	monitor_viol_if.src      viol
);

	logic [NUM_IDS-1:0] aw_map;     // Write address accepted
	logic [NUM_IDS-1:0] wc_map;     // Write data complete
	logic [NUM_IDS-1:0] rd_map;     // Read address accepted
	logic               wr_open;    // Data of one write burst still running
	axi_id_t            wr_id_q;    // ID owning the running write data
	axi_id_t            data_id;
	logic               w_done;
	logic               wr_inc, wr_dec, rd_inc, rd_dec;

	// W carries no ID, data belongs to the open burst or to a same-cycle AW
	assign data_id = wr_open ? wr_id_q : ev.aw_id;
	assign w_done  = ev.w_fire && ev.w_last;

	////////////////////
	// Checks
	////////////////////
	assign viol.id_reuse     = (ev.aw_fire && aw_map[ev.aw_id])
		|| (ev.ar_fire && rd_map[ev.ar_id]);
	assign viol.unexpected_b = ev.b_fire && !(aw_map[ev.b_id] && wc_map[ev.b_id]);
	assign viol.unexpected_r = ev.r_fire && !rd_map[ev.r_id];

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			aw_map  <= '0;
			wc_map  <= '0;
			rd_map  <= '0;
			wr_open <= 1'b0;
		end
		else
		begin
			if (ev.b_fire)                          // Release first, set wins
			begin
				aw_map[ev.b_id] <= 1'b0;
				wc_map[ev.b_id] <= 1'b0;
			end
			if (ev.aw_fire)
			begin
				aw_map[ev.aw_id] <= 1'b1;
				wc_map[ev.aw_id] <= 1'b0;
			end
			if (w_done)
				wc_map[data_id] <= 1'b1;
			if (ev.r_fire && ev.r_last)
				rd_map[ev.r_id] <= 1'b0;
			if (ev.ar_fire)
				rd_map[ev.ar_id] <= 1'b1;

			// Single-beat burst with data alongside its AW never opens
			if (ev.aw_fire && !(w_done && !wr_open))
			begin
				wr_open <= 1'b1;
				wr_id_q <= ev.aw_id;
			end
			else if (w_done)
				wr_open <= 1'b0;
		end
	end

	////////////////////
	// Outstanding counts
	////////////////////
	// Only real bitmap transitions move the counts
	assign wr_inc = ev.aw_fire && !aw_map[ev.aw_id];
	assign wr_dec = ev.b_fire && aw_map[ev.b_id];
	assign rd_inc = ev.ar_fire && !rd_map[ev.ar_id];
	assign rd_dec = ev.r_fire && ev.r_last && rd_map[ev.r_id];

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_wr_outstanding <= '0;
			o_rd_outstanding <= '0;
		end
		else
		begin
			o_wr_outstanding <= o_wr_outstanding + CNT_W'(wr_inc) - CNT_W'(wr_dec);
			o_rd_outstanding <= o_rd_outstanding + CNT_W'(rd_inc) - CNT_W'(rd_dec);
		end
	end

	a_wr_count: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		o_wr_outstanding == CNT_W'($countones(aw_map)));
	a_rd_count: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		o_rd_outstanding == CNT_W'($countones(rd_map)));

endmodule

// ==== axi_latency_watch.sv ====
// Stall timers on the AW, W and AR channels and response delay timers for open bursts
`timescale 1ns/1ps

module axi_latency_watch import axi_fields_pkg::*, monitor_pkg::*;
(
	input  logic             i_clk,
	input  logic             i_axi_reset_n,
	axi_event_if.dst         ev,
	input  logic [CNT_W-1:0] i_wr_outstanding,
	input  logic [CNT_W-1:0] i_rd_outstanding,
	monitor_viol_if.src      viol
);

	// Index 0 AW, 1 W, 2 AR
	logic [2:0]             st_valid, st_fire, st_hit;
	logic [STALL_CNT_W-1:0] stall_cnt [3];

	// Index 0 write, 1 read
	logic [1:0]             dl_run, dl_clr, dl_hit;
	logic [DELAY_CNT_W-1:0] delay_cnt [2];

	assign st_valid = {ev.ar_valid, ev.w_valid, ev.aw_valid};
	assign st_fire  = {ev.ar_fire, ev.w_fire, ev.aw_fire};

	////////////////////
	// Stall timers
	////////////////////
	for (genvar g = 0; g < 3; g++)
	begin : g_stall
		always_ff @(posedge i_clk)
		begin
			if (!i_axi_reset_n || !st_valid[g] || st_fire[g])
				stall_cnt[g] <= '0;
			else if (stall_cnt[g] != STALL_CNT_W'(MAX_STALL))
				stall_cnt[g] <= stall_cnt[g] + 1'b1;  // Parks at the limit
		end

		// This edge completes the last allowed stall cycle
		assign st_hit[g] = st_valid[g] && !st_fire[g]
			&& (stall_cnt[g] == STALL_CNT_W'(MAX_STALL - 1));

		a_stall_bound: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
			stall_cnt[g] <= STALL_CNT_W'(MAX_STALL));
	end

	////////////////////
	// Response delay
	////////////////////
	assign dl_run = {i_rd_outstanding != '0, i_wr_outstanding != '0};
	assign dl_clr = {ev.r_fire, ev.b_fire};   // Any R beat counts as progress

	for (genvar g = 0; g < 2; g++)
	begin : g_delay
		always_ff @(posedge i_clk)
		begin
			if (!i_axi_reset_n || !dl_run[g] || dl_clr[g])
				delay_cnt[g] <= '0;
			else if (delay_cnt[g] != DELAY_CNT_W'(MAX_DELAY))
				delay_cnt[g] <= delay_cnt[g] + 1'b1;
		end

		assign dl_hit[g] = dl_run[g] && !dl_clr[g]
			&& (delay_cnt[g] == DELAY_CNT_W'(MAX_DELAY - 1));

		a_delay_bound: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
			delay_cnt[g] <= DELAY_CNT_W'(MAX_DELAY));
	end

	assign viol.aw_stall   = st_hit[0];
	assign viol.w_stall    = st_hit[1];
	assign viol.ar_stall   = st_hit[2];
	assign viol.wr_timeout = dl_hit[0];
	assign viol.rd_timeout = dl_hit[1];

endmodule

// ==== axi_monitor_ctrl.sv ====
// Handshake decode, first-fault latch and error response counter of the AXI monitor
`timescale 1ns/1ps

module axi_monitor_ctrl import axi_fields_pkg::*, monitor_pkg::*;
(
	input  logic                 i_clk,
	input  logic                 i_axi_reset_n,
	input  logic                 i_axi_awvalid,
	input  logic                 i_axi_awready,
	input  axi_id_t              i_axi_awid,
	input  axi_len_t             i_axi_awlen,
	input  logic                 i_axi_wvalid,
	input  logic                 i_axi_wready,
	input  logic                 i_axi_wlast,
	input  logic                 i_axi_bvalid,
	input  logic                 i_axi_bready,
	input  axi_id_t              i_axi_bid,
	input  axi_resp_t            i_axi_bresp,
	input  logic                 i_axi_arvalid,
	input  logic                 i_axi_arready,
	input  axi_id_t              i_axi_arid,
	input  axi_len_t             i_axi_arlen,
	input  logic                 i_axi_rvalid,
	input  logic                 i_axi_rready,
	input  axi_id_t              i_axi_rid,
	input  axi_resp_t            i_axi_rresp,
	input  logic                 i_axi_rlast,
	axi_event_if.src             ev,
	monitor_viol_if.dst          viol,
	output logic                 o_fault,
	output fault_code_t          o_fault_code,
	output logic [ERR_CNT_W-1:0] o_resp_err_count
);

	mon_state_t            state;
	logic [NUM_FAULTS-1:0] viol_vec;     // Bit n set means code n seen
	fault_code_t           next_code;
	logic                  b_err, r_err;
	logic [1:0]            err_inc;
	logic [ERR_CNT_W:0]    err_sum;      // One spare bit for saturation

	////////////////////
	// Event decode
	////////////////////
	assign ev.aw_fire  = i_axi_awvalid && i_axi_awready;
	assign ev.w_fire   = i_axi_wvalid && i_axi_wready;
	assign ev.b_fire   = i_axi_bvalid && i_axi_bready;
	assign ev.ar_fire  = i_axi_arvalid && i_axi_arready;
	assign ev.r_fire   = i_axi_rvalid && i_axi_rready;
	assign ev.aw_id    = i_axi_awid;
	assign ev.aw_len   = i_axi_awlen;
	assign ev.w_last   = i_axi_wlast;
	assign ev.b_id     = i_axi_bid;
	assign ev.ar_id    = i_axi_arid;
	assign ev.ar_len   = i_axi_arlen;
	assign ev.r_id     = i_axi_rid;
	assign ev.r_last   = i_axi_rlast;
	assign ev.aw_valid = i_axi_awvalid;
	assign ev.w_valid  = i_axi_wvalid;
	assign ev.ar_valid = i_axi_arvalid;

	////////////////////
	// Fault priority
	////////////////////
	assign viol_vec = {viol.len_limit, viol.r_interleave, viol.burst_len_r, viol.burst_len_w,
		viol.w_no_addr, viol.unexpected_r, viol.unexpected_b, viol.id_reuse,
		viol.rd_timeout, viol.wr_timeout, viol.ar_stall, viol.w_stall, viol.aw_stall, 1'b0};

	// Walk down so the lowest code set is the one kept
	always_comb
	begin
		next_code = NONE;
		for (int i = NUM_FAULTS - 1; i >= 1; i--)
			if (viol_vec[i])
				next_code = fault_code_t'(i);
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			state        <= RESET;
			o_fault_code <= NONE;
		end
		else
		begin
			case (state)
				RESET, ARMED:
				begin
					if (|viol_vec)
					begin
						state        <= FAULTED;
						o_fault_code <= next_code;  // First fault only
					end
					else
						state <= ARMED;
				end
				default: state <= state;              // FAULTED holds until reset
			endcase
		end
	end

	assign o_fault = (state == FAULTED);

	////////////////////
	// Error responses
	////////////////////
	assign b_err   = ev.b_fire && i_axi_bresp[1];  // SLVERR or DECERR
	assign r_err   = ev.r_fire && i_axi_rresp[1];
	assign err_inc = {1'b0, b_err} + {1'b0, r_err};
	assign err_sum = o_resp_err_count + err_inc;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_resp_err_count <= '0;
		else if (err_sum[ERR_CNT_W])
			o_resp_err_count <= '1;                   // Saturate
		else
			o_resp_err_count <= err_sum[ERR_CNT_W-1:0];
	end

	// A code is held exactly while faulted
	a_code_matches_state: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(o_fault_code != NONE) == (state == FAULTED));

endmodule

// ==== axi_protocol_monitor.sv ====
// Top level of the passive AXI protocol monitor, watches one port and reports the first fault
`timescale 1ns/1ps

module axi_protocol_monitor import axi_fields_pkg::*, monitor_pkg::*;
(
	input  logic                 i_clk,
	input  logic                 i_axi_reset_n,
	input  logic                 i_axi_awvalid,
	input  logic                 i_axi_awready,
	input  axi_id_t              i_axi_awid,
	input  axi_len_t             i_axi_awlen,
	input  logic                 i_axi_wvalid,
	input  logic                 i_axi_wready,
	input  logic                 i_axi_wlast,
	input  logic                 i_axi_bvalid,
	input  logic                 i_axi_bready,
	input  axi_id_t              i_axi_bid,
	input  axi_resp_t            i_axi_bresp,
	input  logic                 i_axi_arvalid,
	input  logic                 i_axi_arready,
	input  axi_id_t              i_axi_arid,
	input  axi_len_t             i_axi_arlen,
	input  logic                 i_axi_rvalid,
	input  logic                 i_axi_rready,
	input  axi_id_t              i_axi_rid,
	input  axi_resp_t            i_axi_rresp,
	input  logic                 i_axi_rlast,
	output logic                 o_fault,
	output fault_code_t          o_fault_code,
	output logic [CNT_W-1:0]     o_wr_outstanding,
	output logic [CNT_W-1:0]     o_rd_outstanding,
	output logic [ERR_CNT_W-1:0] o_resp_err_count
);

	axi_event_if    u_ev ();    // Decoded handshakes
	monitor_viol_if u_viol ();  // Violation strobes

	axi_monitor_ctrl u_ctrl (
		.i_clk, .i_axi_reset_n,
		.i_axi_awvalid, .i_axi_awready, .i_axi_awid, .i_axi_awlen,
		.i_axi_wvalid, .i_axi_wready, .i_axi_wlast,
		.i_axi_bvalid, .i_axi_bready, .i_axi_bid, .i_axi_bresp,
		.i_axi_arvalid, .i_axi_arready, .i_axi_arid, .i_axi_arlen,
		.i_axi_rvalid, .i_axi_rready, .i_axi_rid, .i_axi_rresp, .i_axi_rlast,
		.ev               (u_ev.src),
		.viol             (u_viol.dst),
		.o_fault, .o_fault_code, .o_resp_err_count
	);

	axi_latency_watch u_latency (
		.i_clk, .i_axi_reset_n,
		.ev               (u_ev.dst),
		.i_wr_outstanding (o_wr_outstanding),
		.i_rd_outstanding (o_rd_outstanding),
		.viol             (u_viol.src)
	);

	axi_id_tracker u_ids (
		.i_clk, .i_axi_reset_n,
		.ev               (u_ev.dst),
		.o_wr_outstanding, .o_rd_outstanding,
		.viol             (u_viol.src)
	);

	axi_burst_checker u_bursts (
		.i_clk, .i_axi_reset_n,
		.ev               (u_ev.dst),
		.viol             (u_viol.src)
	);

endmodule

// ==== monitor_pkg.sv ====
// Monitor limits, fault codes and state encoding used by the control and checker blocks
package monitor_pkg;

	////////////////////
	// Limits
	////////////////////
	localparam int MAX_STALL   = 8;   // Valid without ready, in cycles
	localparam int MAX_DELAY   = 16;  // No response while bursts are open
	localparam int MAX_BURST   = 15;  // Largest legal AxLEN
	localparam int ERR_CNT_W   = 8;   // Error response counter
	localparam int NUM_FAULTS  = 14;  // Fault codes including NONE

	// Timer widths, each holds its own limit
	localparam int STALL_CNT_W = $clog2(MAX_STALL + 1);
	localparam int DELAY_CNT_W = $clog2(MAX_DELAY + 1);

	// Lowest value wins when several fire together
	typedef enum logic [3:0] {
		NONE         = 4'd0,
		AW_STALL     = 4'd1,
		W_STALL      = 4'd2,
		AR_STALL     = 4'd3,
		WR_TIMEOUT   = 4'd4,
		RD_TIMEOUT   = 4'd5,
		ID_REUSE     = 4'd6,
		UNEXPECTED_B = 4'd7,
		UNEXPECTED_R = 4'd8,
		W_NO_ADDR    = 4'd9,
		BURST_LEN_W  = 4'd10,
		BURST_LEN_R  = 4'd11,
		R_INTERLEAVE = 4'd12,
		LEN_LIMIT    = 4'd13
	} fault_code_t;

	typedef enum logic [1:0] {
		RESET   = 2'd0,  // First cycle out of reset
		ARMED   = 2'd1,  // Watching
		FAULTED = 2'd2   // Sticky until reset
	} mon_state_t;

endpackage

// ==== monitor_viol_if.sv ====
// Violation strobes from the checkers back to the fault latch, one per fault code
`timescale 1ns/1ps

interface monitor_viol_if ();

	logic aw_stall;      // Latency watch
	logic w_stall;
	logic ar_stall;
	logic wr_timeout;
	logic rd_timeout;
	logic id_reuse;      // ID tracker
	logic unexpected_b;
	logic unexpected_r;
	logic w_no_addr;     // Burst checker
	logic burst_len_w;
	logic burst_len_r;
	logic r_interleave;
	logic len_limit;

	modport src (output aw_stall, w_stall, ar_stall, wr_timeout, rd_timeout, id_reuse,
		unexpected_b, unexpected_r, w_no_addr, burst_len_w, burst_len_r, r_interleave,
		len_limit);
	modport dst (input aw_stall, w_stall, ar_stall, wr_timeout, rd_timeout, id_reuse,
		unexpected_b, unexpected_r, w_no_addr, burst_len_w, burst_len_r, r_interleave,
		len_limit);

endinterface

// ==== tb_axi_tasks.svh ====
// Stimulus tasks, random draws and bounded waits that the monitor testbench top includes

////////////////////
// Random draws
////////////////////
function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic int unsigned draw(input int unsigned range);
	rng = xorshift(rng);                 // Advance shared state
	return rng % range;
endfunction

function automatic axi_resp_t pick_resp();
	return (draw(4) == 0) ? SLVERR : OKAY;  // About one in four is an error
endfunction

// Inputs change and outputs are read 1 ns after the edge
task automatic next_cycle();
	@(posedge i_clk);
	#1;
endtask

task automatic idle_bus();
	i_axi_awvalid = 1'b0;
	i_axi_awready = 1'b0;
	i_axi_awid    = '0;
	i_axi_awlen   = '0;
	i_axi_wvalid  = 1'b0;
	i_axi_wready  = 1'b0;
	i_axi_wlast   = 1'b0;
	i_axi_bvalid  = 1'b0;
	i_axi_bready  = 1'b0;
	i_axi_bid     = '0;
	i_axi_bresp   = OKAY;
	i_axi_arvalid = 1'b0;
	i_axi_arready = 1'b0;
	i_axi_arid    = '0;
	i_axi_arlen   = '0;
	i_axi_rvalid  = 1'b0;
	i_axi_rready  = 1'b0;
	i_axi_rid     = '0;
	i_axi_rresp   = OKAY;
	i_axi_rlast   = 1'b0;
endtask

////////////////////
// Channel drivers
////////////////////
task automatic send_aw(input axi_id_t id, input axi_len_t len, input int stall);
	i_axi_awvalid = 1'b1;
	i_axi_awid    = id;
	i_axi_awlen   = len;
	repeat (stall) next_cycle();         // Slave holds off
	i_axi_awready = 1'b1;
	next_cycle();
	i_axi_awvalid = 1'b0;
	i_axi_awready = 1'b0;
endtask

task automatic send_ar(input axi_id_t id, input axi_len_t len, input int stall);
	i_axi_arvalid = 1'b1;
	i_axi_arid    = id;
	i_axi_arlen   = len;
	repeat (stall) next_cycle();
	i_axi_arready = 1'b1;
	next_cycle();
	i_axi_arvalid = 1'b0;
	i_axi_arready = 1'b0;
endtask

task automatic send_w(input int beats);
	for (int i = 0; i < beats; i++)
	begin
		i_axi_wvalid = 1'b1;
		i_axi_wready = 1'b1;
		i_axi_wlast  = (i == beats - 1);   // Last on the final beat driven
		next_cycle();
	end
	i_axi_wvalid = 1'b0;
	i_axi_wready = 1'b0;
	i_axi_wlast  = 1'b0;
endtask

task automatic send_b(input axi_id_t id, input axi_resp_t resp);
	i_axi_bvalid = 1'b1;
	i_axi_bready = 1'b1;
	i_axi_bid    = id;
	i_axi_bresp  = resp;
	next_cycle();
	i_axi_bvalid = 1'b0;
	i_axi_bready = 1'b0;
endtask

task automatic send_r(input axi_id_t id, input int beats);
	for (int i = 0; i < beats; i++)
	begin
		i_axi_rvalid = 1'b1;
		i_axi_rready = 1'b1;
		i_axi_rid    = id;
		i_axi_rresp  = pick_resp();
		i_axi_rlast  = (i == beats - 1);
		next_cycle();
	end
	i_axi_rvalid = 1'b0;
	i_axi_rready = 1'b0;
	i_axi_rlast  = 1'b0;
endtask

////////////////////
// Legal traffic
////////////////////
task automatic legal_write();
	axi_id_t  id;
	axi_len_t len;
	id  = axi_id_t'(draw(NUM_IDS));
	len = axi_len_t'(draw(8));           // Up to 8 beats
	send_aw(id, len, draw(MAX_STALL));
	send_w(int'(len) + 1);               // Data only after its address
	send_b(id, pick_resp());
endtask

// Two reads on distinct IDs answered in order without interleave
task automatic legal_reads();
	axi_id_t  id_a;
	axi_id_t  id_b;
	axi_len_t len_a;
	axi_len_t len_b;
	id_a  = axi_id_t'(draw(NUM_IDS));
	id_b  = id_a ^ axi_id_t'(draw(NUM_IDS - 1) + 1);  // Nonzero xor keeps them apart
	len_a = axi_len_t'(draw(8));
	len_b = axi_len_t'(draw(8));
	send_ar(id_a, len_a, draw(MAX_STALL));
	send_ar(id_b, len_b, draw(MAX_STALL));   // Short enough to stay under MAX_DELAY
	send_r(id_a, int'(len_a) + 1);
	send_r(id_b, int'(len_b) + 1);
endtask

////////////////////
// Bounded waits
////////////////////
task automatic wait_fault(input int limit, input string what);
	int n;
	n = 0;
	while (!o_fault && n < limit)
	begin
		next_cycle();
		n++;
	end
	if (!o_fault)
		abort_run($sformatf("Timeout: no fault for %s within %0d cycles", what, limit));
	else
		next_cycle();                    // One edge with the fault visible to the code check
endtask

task automatic wait_drained(input int limit);
	int n;
	n = 0;
	while ((o_wr_outstanding != '0 || o_rd_outstanding != '0) && n < limit)
	begin
		next_cycle();
		n++;
	end
	if (o_wr_outstanding != '0 || o_rd_outstanding != '0)
		abort_run("Timeout: outstanding bursts did not drain after legal traffic");
	else
		next_cycle();                    // Last responses reach the checks
endtask

// ==== tb_axi_monitor.sv ====
// Testbench top for the AXI protocol monitor that runs legal traffic and then one illegal case per reset
`timescale 1ns/1ps

module tb_axi_monitor import axi_fields_pkg::*, monitor_pkg::*; ();

	logic                 i_clk;
	logic                 i_axi_reset_n;
	logic                 i_axi_awvalid;
	logic                 i_axi_awready;
	axi_id_t              i_axi_awid;
	axi_len_t             i_axi_awlen;
	logic                 i_axi_wvalid;
	logic                 i_axi_wready;
	logic                 i_axi_wlast;
	logic                 i_axi_bvalid;
	logic                 i_axi_bready;
	axi_id_t              i_axi_bid;
	axi_resp_t            i_axi_bresp;
	logic                 i_axi_arvalid;
	logic                 i_axi_arready;
	axi_id_t              i_axi_arid;
	axi_len_t             i_axi_arlen;
	logic                 i_axi_rvalid;
	logic                 i_axi_rready;
	axi_id_t              i_axi_rid;
	axi_resp_t            i_axi_rresp;
	logic                 i_axi_rlast;
	logic                 o_fault;
	fault_code_t          o_fault_code;
	logic [CNT_W-1:0]     o_wr_outstanding;
	logic [CNT_W-1:0]     o_rd_outstanding;
	logic [ERR_CNT_W-1:0] o_resp_err_count;

	logic [31:0]          rng;           // xorshift state
	fault_code_t          exp_code;      // Code the current case should raise
	bit                   model_on;      // Count model valid only for legal traffic
	logic [CNT_W-1:0]     exp_wr;
	logic [CNT_W-1:0]     exp_rd;
	logic [ERR_CNT_W-1:0] exp_err;

	axi_protocol_monitor uut (.*);

	always #10 i_clk = ~i_clk;           // 20 ns period

	`include "tb_axi_tasks.svh"

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic report_error(input string msg);
		abort_run($sformatf("ERROR %0t: %s", $time, msg));
	endtask

	task automatic apply_reset(input fault_code_t code, input bit counts_on);
		idle_bus();
		i_axi_reset_n = 1'b0;
		exp_code      = code;
		model_on      = counts_on;
		repeat (3) next_cycle();
		i_axi_reset_n = 1'b1;
	endtask

	////////////////////
	// Reference model
	////////////////////
	// Counts move at the edge that sees the fire
	always @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			exp_wr  <= '0;
			exp_rd  <= '0;
			exp_err <= '0;
		end
		else
		begin
			exp_wr  <= exp_wr + CNT_W'(i_axi_awvalid && i_axi_awready)
				- CNT_W'(i_axi_bvalid && i_axi_bready);
			exp_rd  <= exp_rd + CNT_W'(i_axi_arvalid && i_axi_arready)
				- CNT_W'(i_axi_rvalid && i_axi_rready && i_axi_rlast);
			exp_err <= exp_err + ERR_CNT_W'(i_axi_bvalid && i_axi_bready && i_axi_bresp[1])
				+ ERR_CNT_W'(i_axi_rvalid && i_axi_rready && i_axi_rresp[1]);
		end
	end

	////////////////////
	// Checks
	////////////////////
	a_counts_match: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n || !model_on)
		o_wr_outstanding == exp_wr && o_rd_outstanding == exp_rd && o_resp_err_count == exp_err)
		else report_error($sformatf("counts wr %0d rd %0d err %0d, model wr %0d rd %0d err %0d",
			$sampled(o_wr_outstanding), $sampled(o_rd_outstanding),
			$sampled(o_resp_err_count), $sampled(exp_wr), $sampled(exp_rd),
			$sampled(exp_err)));

	// Any fault must carry the code of the running case and keep it until reset
	a_fault_code: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		o_fault |-> (exp_code != NONE && o_fault_code == exp_code))
		else report_error($sformatf("fault code %0d, expected %0d",
			$sampled(o_fault_code), $sampled(exp_code)));

	a_reset_clear: assert property (@(posedge i_clk) $rose(i_axi_reset_n) |->
		(!o_fault && o_fault_code == NONE && o_wr_outstanding == '0
		&& o_rd_outstanding == '0 && o_resp_err_count == '0))
		else report_error("outputs not cleared after reset");

	initial
	begin
		axi_id_t  id;
		axi_len_t len;
		i_clk = 1'b0;
		rng   = 32'h718f;
		apply_reset(NONE, 1'b1);          // Also sets every input at time 0

		// Legal mix with SLVERR now and then
		repeat (12)
		begin
			legal_write();
			legal_reads();
		end
		wait_drained(MAX_DELAY);

		apply_reset(AW_STALL, 1'b0);
		i_axi_awvalid = 1'b1;             // Ready never comes
		wait_fault(MAX_STALL + 2, "AW stall");
		apply_reset(AR_STALL, 1'b0);
		i_axi_arvalid = 1'b1;
		wait_fault(MAX_STALL + 2, "AR stall");

		apply_reset(UNEXPECTED_B, 1'b0);
		send_b(axi_id_t'(draw(NUM_IDS)), OKAY);   // No write ever issued
		wait_fault(2, "unexpected B");
		apply_reset(ID_REUSE, 1'b0);
		id = axi_id_t'(draw(NUM_IDS));
		send_ar(id, '0, 0);
		send_ar(id, '0, 0);               // Same ID still open
		wait_fault(2, "AR ID reuse");

		apply_reset(BURST_LEN_W, 1'b0);
		len = axi_len_t'(draw(7) + 1);    // At least two beats
		send_aw(axi_id_t'(draw(NUM_IDS)), len, 0);
		send_w(int'(len));                // Last one beat early
		wait_fault(2, "short write burst");
		apply_reset(BURST_LEN_R, 1'b0);
		id  = axi_id_t'(draw(NUM_IDS));
		len = axi_len_t'(draw(8));
		send_ar(id, len, 0);
		send_r(id, int'(len) + 2);        // One beat too many
		wait_fault(2, "long read burst");

		apply_reset(RD_TIMEOUT, 1'b0);
		send_ar(axi_id_t'(draw(NUM_IDS)), axi_len_t'(draw(8)), 0);
		wait_fault(MAX_DELAY + 2, "read response timeout");
		send_b(axi_id_t'(draw(NUM_IDS)), OKAY);   // Second violation must leave the code alone
		repeat (4) next_cycle();

		apply_reset(NONE, 1'b0);          // Sticky fault clears here
		repeat (2) next_cycle();
		$display("TEST PASSED");
		$finish;
	end

endmodule
